/* files.f */
rv_pkg.sv
regfile_2r1w.sv
imm_gen.sv
rv_decoder.sv
id_stage.sv
tb_clkgen.sv
id_stage_chk.sv
id_stage_tb.sv

/* id_stage_tb.sv */
module id_stage_tb import rv_pkg::*; ();

	logic      clk;
	logic      rst_n;
	instr_t    if_instr;
	xlen_t     if_pc;
	logic      ex_ready;
	logic      ex_flush;
	logic      wb_wr_en;
	reg_addr_t wb_wr_addr;
	xlen_t     wb_wr_data;
	logic      id_ready;
	id_ex_t    id2ex;
	string     cur_test;
	int        test_errs;
	int        n_pass;
	int        n_fail;

	tb_clkgen u_clk (.clk(clk), .rst_n(rst_n));

	id_stage dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_if_instr    (if_instr),
		.i_if_pc       (if_pc),
		.i_ex_ready    (ex_ready),
		.i_ex_flush_id (ex_flush),
		.i_wb_wr_en    (wb_wr_en),
		.i_wb_wr_addr  (wb_wr_addr),
		.i_wb_wr_data  (wb_wr_data),
		.o_id_ready    (id_ready),
		.o_id2ex       (id2ex)
	);

	bind id_stage id_stage_chk u_chk (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_ex_ready    (i_ex_ready),
		.i_ex_flush_id (i_ex_flush_id),
		.i_id_ready    (o_id_ready),
		.i_id2ex       (o_id2ex)
	);

	// instruction encoders, immediates given as plain offsets
	function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd,
			input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction
	function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
			input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction
	function automatic instr_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction
	function automatic instr_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
			input reg_addr_t rs1, input logic [2:0] f3, input logic [6:0] opc);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
	endfunction
	function automatic instr_t u_type(input logic [19:0] imm, input reg_addr_t rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction
	function automatic instr_t j_type(input logic [20:0] imm, input reg_addr_t rd,
			input logic [6:0] opc);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
	endfunction

	// expected control word of a legal instruction
	function automatic id_ctrl_t ctrl_of(input imm_fmt_e fmt, input alu_op_e op,
			input logic src, input br_type_e br, input logic wr, input logic mrd,
			input logic mwr, input mem_unit_e unit, input logic uns, input reg_addr_t rd,
			input logic word);
		return '{fmt, op, src, br, br != BR_NONE, mrd, mwr, unit, uns, mrd, wr,
			wr ? rd : 5'd0, word, 1'b1};
	endfunction

	task automatic check_ctrl(input id_ctrl_t exp, input id_ctrl_t act);
		if (act !== exp) begin
			$display("MISMATCH %s ctrl expected %h actual %h", cur_test, exp, act);
			test_errs++;
		end
	endtask
	task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask
	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %b actual %b", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask
	task automatic end_test();
		if (test_errs == 0) begin
			$display("PASS %s", cur_test);
			n_pass++;
		end else begin
			$display("FAIL %s (%0d errors)", cur_test, test_errs);
			n_fail++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#10;	// drive point after the edge
	endtask

	// hand one instruction over and sample the bundle after the loading edge
	task automatic present(input instr_t instr, input xlen_t pc);
		int cycles;
		if_instr = instr;
		if_pc    = pc;
		ex_ready = 1'b1;
		ex_flush = 1'b0;
		cycles   = 0;
		#1;
		while (id_ready !== 1'b1 && cycles < 20) begin
			next_cycle();
			cycles++;
		end
		if (id_ready !== 1'b1) begin
			$display("ERROR %s: decode stage not ready within 20 cycles", cur_test);
			test_errs++;
		end
		next_cycle();
	endtask

	task automatic write_reg(input reg_addr_t addr, input xlen_t data);
		wb_wr_en   = 1'b1;
		wb_wr_addr = addr;
		wb_wr_data = data;
		next_cycle();
		wb_wr_en   = 1'b0;
	endtask

	task automatic decode_and_check(input instr_t instr, input xlen_t exp_imm,
			input id_ctrl_t exp_ctrl);
		xlen_t pc;
		pc = {$urandom, $urandom} & ~64'h3;
		present(instr, pc);
		check_word("pc", pc, id2ex.pc);
		check_word("imm", exp_imm, id2ex.imm);
		check_ctrl(exp_ctrl, id2ex.ctrl);
	endtask

	task automatic reset_and_ready();
		int cycles;
		begin_test("reset_and_ready");
		cycles = 0;
		while (rst_n !== 1'b1 && cycles < 20) begin
			next_cycle();
			cycles++;
		end
		if (rst_n !== 1'b1) begin
			$display("ERROR %s: reset was never released", cur_test);
			test_errs++;
		end
		next_cycle();	// ready still low, register keeps its reset value
		check_word("pc", '0, id2ex.pc);
		check_word("rs1_data", '0, id2ex.rs1_data);
		check_word("rs2_data", '0, id2ex.rs2_data);
		check_word("imm", '0, id2ex.imm);
		check_ctrl('0, id2ex.ctrl);
		#1;
		check_bit("o_id_ready", 1'b0, id_ready);
		ex_ready = 1'b1;
		#1;
		check_bit("o_id_ready", 1'b1, id_ready);
		end_test();
	endtask

	task automatic regfile_rw();
		reg_addr_t r;
		xlen_t     v;
		begin_test("regfile_rw");
		for (int k = 0; k < 8; k++) begin
			r = reg_addr_t'($urandom_range(31, 1));
			v = {$urandom, $urandom};
			write_reg(r, v);
			present(r_type(F7_BASE, 5'd0, r, F3_ADD, 5'd1, OPC_OP), 64'h0);
			check_word("rs1_data", v, id2ex.rs1_data);
			check_word("rs2_data", '0, id2ex.rs2_data);
			present(r_type(F7_BASE, r, 5'd0, F3_ADD, 5'd1, OPC_OP), 64'h0);	// b port
			check_word("rs1_data", '0, id2ex.rs1_data);
			check_word("rs2_data", v, id2ex.rs2_data);
		end
		write_reg(5'd0, {$urandom, $urandom});	// x0 must stay zero
		present(r_type(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd1, OPC_OP), 64'h0);
		check_word("x0 read", '0, id2ex.rs1_data);
		end_test();
	endtask

	task automatic arith(input logic [6:0] opc, input logic [2:0] f3, input logic [6:0] f7,
			input alu_op_e op);
		reg_addr_t rd;
		logic      src;
		rd  = $urandom;
		src = (opc == OPC_IMM) || (opc == OPC_IMM_32);
		present(r_type(f7, reg_addr_t'($urandom), reg_addr_t'($urandom), f3, rd, opc), 64'h40);
		check_ctrl(ctrl_of(src ? IMM_I : IMM_NONE, op, src, BR_NONE, 1'b1, 1'b0, 1'b0, MEM_B,
			1'b0, rd, (opc == OPC_OP_32) || (opc == OPC_IMM_32)), id2ex.ctrl);
	endtask

	task automatic arith_decode();
		alu_op_e base_ops [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};	// by funct3
		begin_test("arith_decode");
		for (int k = 0; k < 8; k++) begin
			arith(OPC_OP, 3'(k), F7_BASE, base_ops[k]);
			arith(OPC_IMM, 3'(k), (k == 1 || k == 5) ? F7_BASE : 7'($urandom), base_ops[k]);
		end
		arith(OPC_OP, F3_ADD, F7_ALT, SUB);
		arith(OPC_OP, F3_SR, F7_ALT, SRA);
		arith(OPC_IMM, F3_SR, F7_ALT, SRA);
		arith(OPC_OP_32, F3_ADD, F7_BASE, ADD);
		arith(OPC_OP_32, F3_ADD, F7_ALT, SUB);
		arith(OPC_OP_32, F3_SLL, F7_BASE, SLL);
		arith(OPC_OP_32, F3_SR, F7_BASE, SRL);
		arith(OPC_OP_32, F3_SR, F7_ALT, SRA);
		arith(OPC_IMM_32, F3_ADD, 7'($urandom), ADD);
		arith(OPC_IMM_32, F3_SLL, F7_BASE, SLL);
		arith(OPC_IMM_32, F3_SR, F7_BASE, SRL);
		arith(OPC_IMM_32, F3_SR, F7_ALT, SRA);
		end_test();
	endtask

	task automatic imm_mem_ctl();
		reg_addr_t   rd;
		logic [11:0] i12;
		logic [12:0] b13;
		logic [19:0] u20;
		logic [20:0] j21;
		logic [2:0]  f3;
		begin_test("imm_mem_ctl");
		rd  = $urandom;
		i12 = $urandom;
		u20 = $urandom;
		j21 = $urandom;
		decode_and_check(u_type(u20, rd, OPC_LUI), {{32{u20[19]}}, u20, 12'h0},
			ctrl_of(IMM_U, LUI, 1'b1, BR_NONE, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, rd, 1'b0));
		decode_and_check(u_type(u20, rd, OPC_AUIPC), {{32{u20[19]}}, u20, 12'h0},
			ctrl_of(IMM_U, AUIPC, 1'b1, BR_NONE, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, rd, 1'b0));
		decode_and_check(j_type(j21, rd, OPC_JAL), {{43{j21[20]}}, j21[20:1], 1'b0},
			ctrl_of(IMM_J, ADD, 1'b1, BR_JUMP, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, rd, 1'b0));
		decode_and_check(i_type(i12, 5'd3, F3_JALR, rd, OPC_JALR), {{52{i12[11]}}, i12},
			ctrl_of(IMM_I, ADD, 1'b1, BR_JUMP, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0, rd, 1'b0));
		for (int k = 0; k < 6; k++) begin
			f3  = (k < 2) ? 3'(k) : 3'(k + 2);	// funct3 010 and 011 unused
			b13 = $urandom;
			decode_and_check(b_type(b13, 5'd2, 5'd1, f3, OPC_BRANCH),
				{{51{b13[12]}}, b13[12:1], 1'b0}, ctrl_of(IMM_B, SUB, 1'b0,
				br_type_e'(int'(BEQ) + k), 1'b0, 1'b0, 1'b0, MEM_B, 1'b0, rd, 1'b0));
		end
		for (int k = 0; k < 7; k++) begin
			f3  = 3'(k);
			i12 = $urandom;
			decode_and_check(i_type(i12, 5'd4, f3, rd, OPC_LOAD), {{52{i12[11]}}, i12},
				ctrl_of(IMM_I, ADD, 1'b1, BR_NONE, 1'b1, 1'b1, 1'b0, mem_unit_e'(f3[1:0]),
				f3[2], rd, f3 == F3_LWU));
		end
		for (int k = 0; k < 4; k++) begin
			f3  = 3'(k);
			i12 = $urandom;
			decode_and_check(s_type(i12, 5'd5, 5'd6, f3, OPC_STORE), {{52{i12[11]}}, i12},
				ctrl_of(IMM_S, ADD, 1'b1, BR_NONE, 1'b0, 1'b0, 1'b1, mem_unit_e'(f3[1:0]),
				1'b0, rd, 1'b0));
		end
		end_test();
	endtask

	task automatic expect_invalid(input instr_t instr);
		present(instr, 64'h80);
		check_bit("is_valid", 1'b0, id2ex.ctrl.is_valid);
		check_bit("rf_wr", 1'b0, id2ex.ctrl.rf_wr);
		check_bit("mem_rd", 1'b0, id2ex.ctrl.mem_rd);
		check_bit("mem_wr", 1'b0, id2ex.ctrl.mem_wr);
		check_bit("is_branch", 1'b0, id2ex.ctrl.is_branch);
	endtask

	task automatic invalid_encodings();
		begin_test("invalid_encodings");
		expect_invalid(32'h0000_00ff);	// opcode 1111111
		expect_invalid(i_type(12'h010, 5'd1, 3'b111, 5'd2, OPC_LOAD));
		expect_invalid(r_type(7'h01, 5'd2, 5'd1, F3_ADD, 5'd3, OPC_OP));
		expect_invalid(r_type(7'h10, 5'd2, 5'd1, F3_SR, 5'd3, OPC_IMM_32));
		end_test();
	endtask

	task automatic hold_and_flush();
		begin_test("hold_and_flush");
		present(r_type(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd7, OPC_OP), 64'h1000);
		if_instr = r_type(F7_BASE, 5'd4, 5'd3, F3_OR, 5'd9, OPC_OP);
		if_pc    = 64'h2000;
		ex_ready = 1'b0;
		next_cycle();
		check_word("held pc", 64'h1000, id2ex.pc);
		check_ctrl(ctrl_of(IMM_NONE, XOR, 1'b0, BR_NONE, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0,
			5'd7, 1'b0), id2ex.ctrl);
		ex_flush = 1'b1;
		ex_ready = 1'b1;	// flush still wins
		next_cycle();
		check_word("flushed pc", '0, id2ex.pc);
		check_ctrl('0, id2ex.ctrl);
		ex_flush = 1'b0;
		next_cycle();
		check_word("pc after flush", 64'h2000, id2ex.pc);
		check_ctrl(ctrl_of(IMM_NONE, OR, 1'b0, BR_NONE, 1'b1, 1'b0, 1'b0, MEM_B, 1'b0,
			5'd9, 1'b0), id2ex.ctrl);
		end_test();
	endtask

	initial begin
		void'($urandom(83305));
		if_instr   = '0;
		if_pc      = '0;
		ex_ready   = 1'b0;
		ex_flush   = 1'b0;
		wb_wr_en   = 1'b0;
		wb_wr_addr = '0;
		wb_wr_data = '0;
		n_pass     = 0;
		n_fail     = 0;
		reset_and_ready();
		regfile_rw();
		arith_decode();
		imm_mem_ctl();
		invalid_encodings();
		hold_and_flush();
		if (dut0.u_chk.fail_count != 0) begin
			$display("bound assertions failed %0d times", dut0.u_chk.fail_count);
			n_fail++;
		end
		$display("%0d tests passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* id_stage_chk.sv */
module id_stage_chk import rv_pkg::*; (
	input logic   clk,
	input logic   rst_n,
	input logic   i_ex_ready,
	input logic   i_ex_flush_id,
	input logic   i_id_ready,
	input id_ex_t i_id2ex
);

	int fail_count = 0;	// bumped on every failed assertion

	ready_passthru: assert property (@(posedge clk) i_id_ready == i_ex_ready)
		else begin
			$error("decode ready does not follow execute ready");
			fail_count++;
		end

	flush_clears: assert property (@(posedge clk) disable iff (!rst_n)
		i_ex_flush_id |=> (i_id2ex == '0))
		else begin
			$error("bundle not cleared one edge after flush");
			fail_count++;
		end

	hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(!i_ex_flush_id && !i_ex_ready) |=> $stable(i_id2ex))
		else begin
			$error("bundle changed while execute stage was stalled");
			fail_count++;
		end

	reset_invalid: assert property (@(posedge clk) $rose(rst_n) |-> !i_id2ex.ctrl.is_valid)
		else begin
			$error("bundle marked valid coming out of reset");
			fail_count++;
		end

endmodule

/* tb_clkgen.sv */
module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// period 100
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;	// released right after the third edge
	end

endmodule

/* id_stage.sv */
module id_stage import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,

	// fetch
	input  instr_t    i_if_instr,
	input  xlen_t     i_if_pc,

	// execute
	input  logic      i_ex_ready,
	input  logic      i_ex_flush_id,

	// write-back
	input  logic      i_wb_wr_en,
	input  reg_addr_t i_wb_wr_addr,
	input  xlen_t     i_wb_wr_data,

	output logic      o_id_ready,
	output id_ex_t    o_id2ex
);

	id_ctrl_t dec_ctrl;
	xlen_t    imm;
	xlen_t    rs1_data;
	xlen_t    rs2_data;
	id_ex_t   id2ex_d;

	regfile_2r1w u_rf (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_raddr_a (i_if_instr[19:15]),	// rs1
		.i_raddr_b (i_if_instr[24:20]),	// rs2
		.i_waddr   (i_wb_wr_addr),
		.i_wen     (i_wb_wr_en),
		.i_wdata   (i_wb_wr_data),
		.o_rdata_a (rs1_data),
		.o_rdata_b (rs2_data)
	);

	imm_gen u_imm (
		.i_fmt   (dec_ctrl.imm_fmt),
		.i_instr (i_if_instr),
		.o_imm   (imm)
	);

	rv_decoder u_dec (
		.i_instr (i_if_instr),
		.o_ctrl  (dec_ctrl)
	);

	assign id2ex_d.pc       = i_if_pc;
	assign id2ex_d.rs1_data = rs1_data;
	assign id2ex_d.rs2_data = rs2_data;
	assign id2ex_d.imm      = imm;
	assign id2ex_d.ctrl     = dec_ctrl;

	assign o_id_ready = i_ex_ready;	// only stall source

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_id2ex <= '0;
		end else if (i_ex_flush_id) begin
			o_id2ex <= '0;	// flush beats load and hold
		end else if (i_ex_ready) begin
			o_id2ex <= id2ex_d;
		end
	end

endmodule

/* rv_decoder.sv */
module rv_decoder import rv_pkg::*; (
	input  instr_t   i_instr,
	output id_ctrl_t o_ctrl
);

	logic [6:0] opcode;
	logic [2:0] f3;
	logic [6:0] f7;
	reg_addr_t  rd_field;
	logic       f7_base;
	logic       f7_alt;
	logic       f6_base;
	logic       f6_alt;
	logic       ok;

	assign opcode   = i_instr[6:0];
	assign f3       = i_instr[14:12];
	assign f7       = i_instr[31:25];
	assign rd_field = i_instr[11:7];
	assign f7_base  = (f7 == F7_BASE);
	assign f7_alt   = (f7 == F7_ALT);

	// RV64 shift immediates carry shamt[5] in bit 25, so only
	// the upper six bits select the operation
	assign f6_base  = (f7[6:1] == F7_BASE[6:1]);
	assign f6_alt   = (f7[6:1] == F7_ALT[6:1]);

	always_comb begin
		o_ctrl = '0;
		ok     = 1'b1;

		unique case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				o_ctrl.imm_fmt = IMM_U;
				o_ctrl.alu_op  = (opcode == OPC_LUI) ? LUI : AUIPC;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.rf_wr   = 1'b1;
			end
			OPC_JAL, OPC_JALR: begin
				o_ctrl.imm_fmt   = (opcode == OPC_JAL) ? IMM_J : IMM_I;
				o_ctrl.alu_op    = ADD;	// link value pc+4
				o_ctrl.alu_src   = 1'b1;
				o_ctrl.br_type   = BR_JUMP;
				o_ctrl.is_branch = 1'b1;
				o_ctrl.rf_wr     = 1'b1;
				if (opcode == OPC_JALR) begin
					ok = (f3 == F3_JALR);
				end
			end
			OPC_BRANCH: begin
				o_ctrl.imm_fmt   = IMM_B;
				o_ctrl.alu_op    = SUB;	// compare rs1 against rs2
				o_ctrl.is_branch = 1'b1;
				case (f3)
					F3_BEQ:  o_ctrl.br_type = BEQ;
					F3_BNE:  o_ctrl.br_type = BNE;
					F3_BLT:  o_ctrl.br_type = BLT;
					F3_BGE:  o_ctrl.br_type = BGE;
					F3_BLTU: o_ctrl.br_type = BLTU;
					F3_BGEU: o_ctrl.br_type = BGEU;
					default: ok = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				o_ctrl.imm_fmt    = IMM_I;
				o_ctrl.alu_op     = ADD;	// address rs1 + imm
				o_ctrl.alu_src    = 1'b1;
				o_ctrl.mem_rd     = 1'b1;
				o_ctrl.mem_to_reg = 1'b1;
				o_ctrl.rf_wr      = 1'b1;
				case (f3)
					F3_LB:   o_ctrl.mem_unit = MEM_B;
					F3_LH:   o_ctrl.mem_unit = MEM_H;
					F3_LW:   o_ctrl.mem_unit = MEM_W;
					F3_LD:   o_ctrl.mem_unit = MEM_D;
					F3_LBU: begin
						o_ctrl.mem_unit     = MEM_B;
						o_ctrl.mem_unsigned = 1'b1;
					end
					F3_LHU: begin
						o_ctrl.mem_unit     = MEM_H;
						o_ctrl.mem_unsigned = 1'b1;
					end
					F3_LWU: begin
						o_ctrl.mem_unit     = MEM_W;
						o_ctrl.mem_unsigned = 1'b1;
						o_ctrl.word_op      = 1'b1;
					end
					default: ok = 1'b0;
				endcase
			end
			OPC_STORE: begin
				o_ctrl.imm_fmt = IMM_S;
				o_ctrl.alu_op  = ADD;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.mem_wr  = 1'b1;	// rs2 is the store data
				case (f3)
					F3_SB:   o_ctrl.mem_unit = MEM_B;
					F3_SH:   o_ctrl.mem_unit = MEM_H;
					F3_SW:   o_ctrl.mem_unit = MEM_W;
					F3_SD:   o_ctrl.mem_unit = MEM_D;
					default: ok = 1'b0;
				endcase
			end
			OPC_IMM: begin
				o_ctrl.imm_fmt = IMM_I;
				o_ctrl.alu_src = 1'b1;
				o_ctrl.rf_wr   = 1'b1;
				unique case (f3)
					F3_ADD:  o_ctrl.alu_op = ADD;
					F3_SLT:  o_ctrl.alu_op = SLT;
					F3_SLTU: o_ctrl.alu_op = SLTU;
					F3_XOR:  o_ctrl.alu_op = XOR;
					F3_OR:   o_ctrl.alu_op = OR;
					F3_AND:  o_ctrl.alu_op = AND;
					F3_SLL: begin
						o_ctrl.alu_op = SLL;
						ok            = f6_base;
					end
					F3_SR: begin
						o_ctrl.alu_op = f6_alt ? SRA : SRL;
						ok            = f6_base | f6_alt;
					end
				endcase
			end
			OPC_OP: begin
				o_ctrl.rf_wr = 1'b1;	// both operands from registers
				ok           = f7_base;
				unique case (f3)
					F3_ADD: begin
						o_ctrl.alu_op = f7_alt ? SUB : ADD;
						ok            = f7_base | f7_alt;
					end
					F3_SLL:  o_ctrl.alu_op = SLL;
					F3_SLT:  o_ctrl.alu_op = SLT;
					F3_SLTU: o_ctrl.alu_op = SLTU;
					F3_XOR:  o_ctrl.alu_op = XOR;
					F3_SR: begin
						o_ctrl.alu_op = f7_alt ? SRA : SRL;
						ok            = f7_base | f7_alt;
					end
					F3_OR:   o_ctrl.alu_op = OR;
					F3_AND:  o_ctrl.alu_op = AND;
				endcase
			end
			OPC_IMM_32, OPC_OP_32: begin
				o_ctrl.imm_fmt = (opcode == OPC_IMM_32) ? IMM_I : IMM_NONE;
				o_ctrl.alu_src = (opcode == OPC_IMM_32);
				o_ctrl.rf_wr   = 1'b1;
				o_ctrl.word_op = 1'b1;
				case (f3)
					F3_ADD: begin
						// ADDIW has no funct7, its bits are immediate
						if (opcode == OPC_OP_32) begin
							o_ctrl.alu_op = f7_alt ? SUB : ADD;
							ok            = f7_base | f7_alt;
						end else begin
							o_ctrl.alu_op = ADD;
						end
					end
					F3_SLL: begin
						o_ctrl.alu_op = SLL;
						ok            = f7_base;
					end
					F3_SR: begin
						o_ctrl.alu_op = f7_alt ? SRA : SRL;
						ok            = f7_base | f7_alt;
					end
					default: ok = 1'b0;
				endcase
			end
			default: ok = 1'b0;	// unknown opcode
		endcase

		// no side effects for illegal encodings
		if (!ok) begin
			o_ctrl.rf_wr     = 1'b0;
			o_ctrl.mem_rd    = 1'b0;
			o_ctrl.mem_wr    = 1'b0;
			o_ctrl.is_branch = 1'b0;
		end
		o_ctrl.is_valid = ok;
		o_ctrl.rd       = o_ctrl.rf_wr ? rd_field : '0;
	end

endmodule

/* imm_gen.sv */
module imm_gen import rv_pkg::*; (
	input  imm_fmt_e i_fmt,
	input  instr_t   i_instr,
	output xlen_t    o_imm
);

	logic sgn;

	assign sgn = i_instr[31];	// every format signs from bit 31

	always_comb begin
		case (i_fmt)
			IMM_I: begin
				o_imm = {{(XLEN-12){sgn}}, i_instr[31:20]};
			end
			IMM_S: begin
				o_imm = {{(XLEN-12){sgn}}, i_instr[31:25], i_instr[11:7]};
			end
			IMM_B: begin
				// 13-bit offset, lsb always zero
				o_imm = {{(XLEN-13){sgn}}, i_instr[31], i_instr[7],
					i_instr[30:25], i_instr[11:8], 1'b0};
			end
			IMM_U: begin
				o_imm = {{(XLEN-32){sgn}}, i_instr[31:12], 12'b0};
			end
			IMM_J: begin
				// 21-bit offset, lsb always zero
				o_imm = {{(XLEN-21){sgn}}, i_instr[31], i_instr[19:12],
					i_instr[20], i_instr[30:21], 1'b0};
			end
			default: begin
				o_imm = '0;	// R-type, no immediate
			end
		endcase
	end

endmodule

/* regfile_2r1w.sv */
module regfile_2r1w import rv_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t i_raddr_a,
	input  reg_addr_t i_raddr_b,
	input  reg_addr_t i_waddr,
	input  logic      i_wen,
	input  xlen_t     i_wdata,
	output xlen_t     o_rdata_a,
	output xlen_t     o_rdata_b
);

	// x0 has no storage
	xlen_t regs [1:NUM_REGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wen && (i_waddr != '0)) begin
			regs[i_waddr] <= i_wdata;	// writes to x0 dropped
		end
	end

	// a write this cycle shows up only after the edge
	always_comb begin
		if (i_raddr_a == '0) begin
			o_rdata_a = '0;
		end else begin
			o_rdata_a = regs[i_raddr_a];
		end
	end

	always_comb begin
		if (i_raddr_b == '0) begin
			o_rdata_b = '0;
		end else begin
			o_rdata_b = regs[i_raddr_b];
		end
	end

endmodule

/* rv_pkg.sv */
package rv_pkg;

	localparam int XLEN       = 64;	// data and pc width
	localparam int ILEN       = 32;	// instruction width
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// major opcodes, instr[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32  = 7'b0111011;

	localparam logic [2:0] F3_JALR = 3'b000;

	// branch conditions
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// load sizes
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LD  = 3'b011;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	localparam logic [2:0] F3_LWU = 3'b110;

	// store sizes
	localparam logic [2:0] F3_SB = 3'b000;
	localparam logic [2:0] F3_SH = 3'b001;
	localparam logic [2:0] F3_SW = 3'b010;
	localparam logic [2:0] F3_SD = 3'b011;

	// integer ops, shared by OP, OP-IMM and the 32-bit groups
	localparam logic [2:0] F3_ADD  = 3'b000;	// also SUB
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;	// SRL and SRA
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	localparam logic [6:0] F7_BASE = 7'h00;
	localparam logic [6:0] F7_ALT  = 7'h20;	// SUB, SRA

	typedef logic [XLEN-1:0]       xlen_t;
	typedef logic [ILEN-1:0]       instr_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	typedef enum logic [2:0] {
		IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
	} imm_fmt_e;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI, AUIPC
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_JUMP, BEQ, BNE, BLT, BGE, BLTU, BGEU
	} br_type_e;

	typedef enum logic [1:0] {
		MEM_B, MEM_H, MEM_W, MEM_D
	} mem_unit_e;

	typedef struct packed {
		imm_fmt_e  imm_fmt;
		alu_op_e   alu_op;
		logic      alu_src;	// operand b is the immediate
		br_type_e  br_type;
		logic      is_branch;
		logic      mem_rd;
		logic      mem_wr;
		mem_unit_e mem_unit;
		logic      mem_unsigned;
		logic      mem_to_reg;
		logic      rf_wr;
		reg_addr_t rd;
		logic      word_op;	// sign-extend 32-bit result
		logic      is_valid;
	} id_ctrl_t;

	typedef struct packed {
		xlen_t    pc;
		xlen_t    rs1_data;
		xlen_t    rs2_data;
		xlen_t    imm;
		id_ctrl_t ctrl;
	} id_ex_t;

endpackage
